// File: rtl/cpc_bus_pkg.sv
// Z80 bus sample type and memory-cycle state encoding
// Timing constants for the write-cycle RD* overdrive tail
`default_nettype none

package cpc_bus_pkg;

  // One clock's sample of the Z80 bus pins
  // Strobes are active low and keep the _b suffix of the pin names
  typedef struct packed {
    logic       mreq_b;
    logic       iorq_b;
    logic       wr_b;
    logic       rd_b;
    logic       m1_b;
    logic       rfsh_b;
    logic       adr15;
    logic       adr14;
    logic       adr8;
    logic [7:0] data;
  } z80_bus_t;

  // Bus with every strobe released and the address and data low
  localparam z80_bus_t bus_idle = '{
    mreq_b: 1'b1, iorq_b: 1'b1, wr_b: 1'b1, rd_b: 1'b1, m1_b: 1'b1, rfsh_b: 1'b1,
    adr15: 1'b0, adr14: 1'b0, adr8: 1'b0, data: 8'h00
  };

  // States of the memory-cycle tracker
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    WRITE = 2'd1,
    READ  = 2'd2,
    TAIL  = 2'd3
  } cycle_state_t;

  // Clocks that RD* stays overdriven after MREQ* rises on an expansion write
  localparam int unsigned rd_tail_cycles = 2;

endpackage

`default_nettype wire

// File: rtl/ram_map_pkg.sv
// Card configuration, bank register and RAM request types
// Bank-select decode constants and the shadow bank helper
`default_nettype none

package ram_map_pkg;

  // Switch settings latched from dip[3:0] while reset is held
  // The field order matches dip[3] down to dip[0]
  typedef struct packed {
    logic overdrive_en;
    logic port_7e;
    logic shadow_en;
    logic shadow_hi;
  } card_cfg_t;

  // Contents of the bank-select register written as 11cccbbb
  typedef struct packed {
    logic [2:0] bank;
    logic [2:0] scheme;
  } bank_reg_t;

  // Registered RAM request for one memory access
  // adr_hi carries the 3-bit bank in its top bits and the 2-bit block below
  typedef struct packed {
    logic       exp_sel;
    logic       ram_cs;
    logic [4:0] adr_hi;
    logic       ramdis;
  } ram_req_t;

  // Top two data bits that mark an I/O write as a bank select
  localparam logic [1:0] bank_sel_prefix = 2'b11;

  // Block that the shadow bank serves to reads in the C3 scheme
  localparam logic [1:0] shadow_block = 2'b11;

  // Scheme code of the C3 mode, which also needs the A15 overdrive
  localparam logic [2:0] scheme_c3 = 3'b011;

  // The shadow bank is one of the two banks whose low bits are both set
  function automatic logic [2:0] shadow_bank(input logic shadow_hi);
    return {shadow_hi, 2'b11};
  endfunction

endpackage

`default_nettype wire

// File: rtl/bank_select_reg.sv
// Bank-select I/O write decoder with the bank register
// Configuration switch latch loaded during reset
`timescale 1ns/10ps
`default_nettype none

module bank_select_reg (
  input  logic                   clk,
  input  logic                   reset_b,
  input  cpc_bus_pkg::z80_bus_t  bus,
  input  logic [3:0]             dip,
  output ram_map_pkg::card_cfg_t cfg,
  output ram_map_pkg::bank_reg_t bank_reg
);
  import ram_map_pkg::*;

  logic       io_armed;
  logic       port_hit;
  logic       sel_wr;
  logic [2:0] ccc;

  assign ccc = bus.data[5:3];

  // Port 7Fxx answers when port_7e is clear and 7Exx when it is set
  assign port_hit = bus.adr8 ^ cfg.port_7e;

  // Only the first qualifying clock of an I/O cycle loads the register
  assign sel_wr = io_armed && !bus.iorq_b && !bus.wr_b && !bus.adr15 &&
                  (bus.data[7:6] == bank_sel_prefix) && port_hit;

  // The switches are sampled on every clock of reset and held once it is released
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      cfg <= card_cfg_t'(dip);
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_b) begin
      io_armed <= 1'b1;
      bank_reg <= '0;
    end else begin
      // Falling edge detect on IORQ* re-arms the decoder between I/O cycles
      if (bus.iorq_b) begin
        io_armed <= 1'b1;
      end else if (sel_wr) begin
        io_armed <= 1'b0;
      end
      if (sel_wr) begin
        // In shadow mode the shadow bank is aliased onto its even neighbour
        if (cfg.shadow_en && (ccc == shadow_bank(cfg.shadow_hi))) begin
          bank_reg.bank <= {ccc[2:1], 1'b0};
        end else begin
          bank_reg.bank <= ccc;
        end
        bank_reg.scheme <= bus.data[2:0];
      end
    end
  end

  // A sample with IORQ* released never changes the mapping on the next clock
  a_no_update_outside_io: assert property (
    @(posedge clk) disable iff (!reset_b) bus.iorq_b |=> $stable(bank_reg)
  );

endmodule

`default_nettype wire

// File: rtl/mem_cycle_fsm.sv
// Memory-cycle tracker FSM
// Classifies each MREQ* cycle as a write or a read and adds a write tail
`timescale 1ns/10ps
`default_nettype none

module mem_cycle_fsm (
  input  logic                      clk,
  input  logic                      reset_b,
  input  cpc_bus_pkg::z80_bus_t     bus,
  input  logic                      tail_done,
  output cpc_bus_pkg::cycle_state_t state,
  output logic                      write_cyc
);
  import cpc_bus_pkg::*;

  cycle_state_t state_d;
  logic         wr_start;

  // A request that is neither refresh, opcode fetch nor read is taken as a write
  // WR* comes later than MREQ* on the Z80, so RD* high is the early sign
  assign wr_start = !bus.mreq_b && bus.rfsh_b && bus.m1_b && bus.rd_b;

  always_comb begin
    state_d = state;
    case (state)
      IDLE: begin
        if (wr_start) begin
          state_d = WRITE;
        end else if (!bus.mreq_b) begin
          state_d = READ;
        end
      end
      WRITE: begin
        // The write tail starts when MREQ* is released
        if (bus.mreq_b) begin
          state_d = TAIL;
        end
      end
      READ: begin
        if (bus.mreq_b) begin
          state_d = IDLE;
        end
      end
      TAIL: begin
        if (tail_done) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_b) begin
      state <= IDLE;
    end else begin
      state <= state_d;
    end
  end

  assign write_cyc = (state == WRITE);

  // The tail only follows a write, so reads and refreshes never stretch RD*
  a_tail_after_write: assert property (
    @(posedge clk) disable iff (!reset_b)
    (state != WRITE) && (state != TAIL) |=> (state != TAIL)
  );

endmodule

`default_nettype wire

// File: rtl/overdrive_timer.sv
// Down-counter that times the RD* overdrive tail after a write cycle
`timescale 1ns/10ps
`default_nettype none

module overdrive_timer (
  input  logic                      clk,
  input  logic                      reset_b,
  input  cpc_bus_pkg::cycle_state_t state,
  output logic                      tail_done
);
  import cpc_bus_pkg::*;

  logic [1:0] count;

  // The count sits at its load value outside TAIL, so entry starts a fresh tail
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      count <= 2'(rd_tail_cycles);
    end else if (state == TAIL) begin
      count <= count - 2'd1;
    end else begin
      count <= 2'(rd_tail_cycles);
    end
  end

  // Last clock of the tail once the count has stepped down to one
  assign tail_done = (state == TAIL) && (count == 2'd1);

  // Done always hands the FSM back to IDLE on the next clock
  a_done_ends_tail: assert property (
    @(posedge clk) disable iff (!reset_b)
    tail_done |=> (state == IDLE)
  );

endmodule

`default_nettype wire

// File: rtl/block_mapper.sv
// Maps the bank scheme and the address quarter onto an expansion block
// Registers the resulting RAM request, including the shadow mode cases
`timescale 1ns/10ps
`default_nettype none

module block_mapper (
  input  logic                   clk,
  input  logic                   reset_b,
  input  ram_map_pkg::bank_reg_t bank_reg,
  input  ram_map_pkg::card_cfg_t cfg,
  input  logic                   adr15,
  input  logic                   adr14,
  input  logic                   write_cyc,
  output ram_map_pkg::ram_req_t  ram_req
);
  import ram_map_pkg::*;

  logic [1:0] q;
  logic [1:0] blk;
  logic       hit;
  ram_req_t   req_d;

  // Address quarter of the current access, 0000 to C000 in 16K steps
  assign q = {adr15, adr14};

  // Scheme decode into an expansion hit and the block it uses
  always_comb begin
    hit = 1'b0;
    blk = 2'b11;
    case (bank_reg.scheme)
      3'b000: begin
        hit = 1'b0;
      end
      3'b001, 3'b011: begin
        // Top 16K window only, always block 3 of the bank
        hit = (q == 2'b11);
        blk = 2'b11;
      end
      3'b010: begin
        // Whole 64K replaced, each quarter maps onto its own block
        hit = 1'b1;
        blk = q;
      end
      default: begin
        // Schemes 4 to 7 page one block into the 4000 window
        hit = (q == 2'b01);
        blk = bank_reg.scheme[1:0];
      end
    endcase
  end

  // Request build from the decode and the shadow settings
  always_comb begin
    req_d = '0;
    if (hit) begin
      req_d.exp_sel = 1'b1;
      req_d.ram_cs  = 1'b1;
      req_d.ramdis  = 1'b1;
      req_d.adr_hi  = {bank_reg.bank, blk};
    end else if (cfg.shadow_en) begin
      if ((bank_reg.scheme == scheme_c3) && (q == 2'b01)) begin
        // C3 reads at 4000 come from the shadow copy of the top block
        req_d.ram_cs = 1'b1;
        req_d.ramdis = 1'b1;
        req_d.adr_hi = {shadow_bank(cfg.shadow_hi), shadow_block};
      end else begin
        // Writes are mirrored into the shadow bank and reads stay internal
        req_d.ram_cs = write_cyc;
        req_d.ramdis = write_cyc;
        req_d.adr_hi = {shadow_bank(cfg.shadow_hi), q};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_b) begin
      ram_req <= '0;
    end else begin
      ram_req <= req_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/cpc_ram_expansion.sv
// Top level of the 512K RAM expansion card
// Bus sample register, block instances and output gating
`timescale 1ns/10ps
`default_nettype none

module cpc_ram_expansion (
  input  logic                  clk,
  input  logic                  reset_b,
  input  cpc_bus_pkg::z80_bus_t bus,
  input  logic [3:0]            dip,
  output logic                  ram_cs_b,
  output logic [4:0]            ram_adr_hi,
  output logic                  ramdis,
  output logic                  a15_drive,
  output logic                  rd_drive
);
  import cpc_bus_pkg::*;
  import ram_map_pkg::*;

  z80_bus_t     bus_q;
  card_cfg_t    cfg;
  bank_reg_t    bank_reg;
  ram_req_t     ram_req;
  cycle_state_t state;
  logic         write_cyc;
  logic         tail_done;
  logic         a15_req;

  // Every block works from this one registered copy of the pins
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      bus_q <= bus_idle;
    end else begin
      bus_q <= bus;
    end
  end

  bank_select_reg u_bank_select_reg (
    .clk      (clk),
    .reset_b  (reset_b),
    .bus      (bus_q),
    .dip      (dip),
    .cfg      (cfg),
    .bank_reg (bank_reg)
  );

  mem_cycle_fsm u_mem_cycle_fsm (
    .clk       (clk),
    .reset_b   (reset_b),
    .bus       (bus_q),
    .tail_done (tail_done),
    .state     (state),
    .write_cyc (write_cyc)
  );

  overdrive_timer u_overdrive_timer (
    .clk       (clk),
    .reset_b   (reset_b),
    .state     (state),
    .tail_done (tail_done)
  );

  block_mapper u_block_mapper (
    .clk       (clk),
    .reset_b   (reset_b),
    .bank_reg  (bank_reg),
    .cfg       (cfg),
    .adr15     (bus_q.adr15),
    .adr14     (bus_q.adr14),
    .write_cyc (write_cyc),
    .ram_req   (ram_req)
  );

  // SRAM is only selected inside a real memory request and never on refresh
  assign ram_cs_b   = !ram_req.ram_cs || bus_q.mreq_b || !bus_q.rfsh_b;
  assign ram_adr_hi = ram_req.adr_hi;
  assign ramdis     = ram_req.ramdis;

  // In C3 mode the gate array must see A15 high for the 4000 window
  // With shadow enabled only writes are redirected this way
  assign a15_req = cfg.overdrive_en && (bank_reg.scheme == scheme_c3) && bus_q.adr14 &&
                   bus_q.rfsh_b && !bus_q.mreq_b && (!cfg.shadow_en || write_cyc);

  // Registered so that A15 follows the pins with the same latency as the request
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      a15_drive <= 1'b0;
    end else begin
      a15_drive <= a15_req;
    end
  end

  // RD* is held through the write and its tail to keep internal RAM off the bus
  assign rd_drive = cfg.overdrive_en && ram_req.exp_sel && ((state == WRITE) || (state == TAIL));

endmodule

`default_nettype wire

// File: tests/tb_cpc_ram_expansion.sv
// Random-stimulus testbench for the 512K RAM expansion card
// Holds a cycle-level reference model of the card and checks every output on each clock
`timescale 1ns/10ps
`default_nettype none

module tb_cpc_ram_expansion;
  import cpc_bus_pkg::*;
  import ram_map_pkg::*;

  localparam int reset_cycles = 10;
  localparam int num_phases   = 8;
  localparam int num_txn      = 400;
  // Longest bus cycle is five clocks plus a gap of two, rounded up
  localparam int run_cycles   = num_phases * (reset_cycles + 1 + num_txn * 8) + 16;
  // Switches per phase, phase 0 in the low nibble; bits are overdrive, port 7E, shadow, shadow_hi
  localparam logic [31:0] phase_dips = 32'hF7BA_C480;

  logic       clk;
  logic       reset_b;
  z80_bus_t   bus;
  logic [3:0] dip;
  logic       ram_cs_b;
  logic [4:0] ram_adr_hi;
  logic       ramdis;
  logic       a15_drive;
  logic       rd_drive;

  // Reference model state, one variable per register of the card
  z80_bus_t     m_bus_q;
  card_cfg_t    m_cfg;
  bank_reg_t    m_bank_reg;
  ram_req_t     m_req;
  cycle_state_t m_state;
  logic [1:0]   m_count;
  logic         m_armed;
  logic         m_a15;
  logic         model_valid;
  int           err_count [5];
  int           check_count;

  cpc_ram_expansion uut (
    .clk        (clk),
    .reset_b    (reset_b),
    .bus        (bus),
    .dip        (dip),
    .ram_cs_b   (ram_cs_b),
    .ram_adr_hi (ram_adr_hi),
    .ramdis     (ramdis),
    .a15_drive  (a15_drive),
    .rd_drive   (rd_drive)
  );

  always #4 clk = ~clk;

  // Mapping table of the card for one access in quarter q
  function automatic ram_req_t map_access(input bank_reg_t br, input card_cfg_t cf,
                                          input logic [1:0] q, input logic wr);
    ram_req_t   r;
    logic       hit;
    logic [1:0] blk;
    r = '0;
    hit = 1'b0;
    blk = 2'b11;
    if (br.scheme == 3'b010) begin
      hit = 1'b1;
      blk = q;
    end else if ((br.scheme == 3'b001) || (br.scheme == 3'b011)) begin
      hit = (q == 2'b11);
    end else if (br.scheme[2]) begin
      hit = (q == 2'b01);
      blk = br.scheme[1:0];
    end
    if (hit) begin
      r.exp_sel = 1'b1;
      r.ram_cs = 1'b1;
      r.ramdis = 1'b1;
      r.adr_hi = {br.bank, blk};
    end else if (cf.shadow_en && (br.scheme == 3'b011) && (q == 2'b01)) begin
      r.ram_cs = 1'b1;
      r.ramdis = 1'b1;
      r.adr_hi = {cf.shadow_hi, 2'b11, shadow_block};
    end else if (cf.shadow_en) begin
      // Only writes land in the shadow bank
      r.ram_cs = wr;
      r.ramdis = wr;
      r.adr_hi = {cf.shadow_hi, 2'b11, q};
    end
    return r;
  endfunction

  // Advances the model by one clock; each register is read before it is overwritten
  task automatic step_model();
    logic       tdone;
    logic       sel;
    logic [2:0] ccc;
    tdone = (m_state == TAIL) && (m_count == 2'd1);
    m_req = map_access(m_bank_reg, m_cfg, {m_bus_q.adr15, m_bus_q.adr14}, m_state == WRITE);
    m_a15 = m_cfg.overdrive_en && (m_bank_reg.scheme == 3'b011) && m_bus_q.adr14 &&
            m_bus_q.rfsh_b && !m_bus_q.mreq_b && (!m_cfg.shadow_en || (m_state == WRITE));
    m_count = (m_state == TAIL) ? m_count - 2'd1 : 2'(rd_tail_cycles);
    if ((m_state == IDLE) && !m_bus_q.mreq_b) begin
      if (m_bus_q.rfsh_b && m_bus_q.m1_b && m_bus_q.rd_b) begin
        m_state = WRITE;
      end else begin
        m_state = READ;
      end
    end else if ((m_state == WRITE) && m_bus_q.mreq_b) begin
      m_state = TAIL;
    end else if ((m_state == READ) && m_bus_q.mreq_b) begin
      m_state = IDLE;
    end else if ((m_state == TAIL) && tdone) begin
      m_state = IDLE;
    end
    // Bank select on the first qualifying clock of an I/O write
    ccc = m_bus_q.data[5:3];
    sel = m_armed && !m_bus_q.iorq_b && !m_bus_q.wr_b && !m_bus_q.adr15 &&
          (m_bus_q.data[7:6] == 2'b11) && (m_bus_q.adr8 != m_cfg.port_7e);
    if (m_bus_q.iorq_b) begin
      m_armed = 1'b1;
    end else if (sel) begin
      m_armed = 1'b0;
    end
    if (sel) begin
      m_bank_reg.bank = ccc;
      if (m_cfg.shadow_en && (ccc == {m_cfg.shadow_hi, 2'b11})) begin
        m_bank_reg.bank[0] = 1'b0;
      end
      m_bank_reg.scheme = m_bus_q.data[2:0];
    end
    m_bus_q = bus;
  endtask

  always @(posedge clk) begin
    if (!reset_b) begin
      m_cfg = card_cfg_t'(dip);
      m_bus_q = bus_idle;
      m_bank_reg = '0;
      m_req = '0;
      m_state = IDLE;
      m_count = 2'(rd_tail_cycles);
      m_armed = 1'b1;
      m_a15 = 1'b0;
    end else begin
      step_model();
    end
    model_valid = 1'b1;
  end

  task automatic compare(input int idx, input string name, input logic [4:0] got,
                         input logic [4:0] exp);
    assert (got === exp) else begin
      err_count[idx]++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (model_valid) begin
      check_count++;
      compare(0, "ram_cs_b", {4'b0, ram_cs_b},
              {4'b0, !m_req.ram_cs || m_bus_q.mreq_b || !m_bus_q.rfsh_b});
      compare(1, "ram_adr_hi", ram_adr_hi, m_req.adr_hi);
      compare(2, "ramdis", {4'b0, ramdis}, {4'b0, m_req.ramdis});
      compare(3, "a15_drive", {4'b0, a15_drive}, {4'b0, m_a15});
      compare(4, "rd_drive", {4'b0, rd_drive},
              {4'b0, m_cfg.overdrive_en && m_req.exp_sel && ((m_state == WRITE) || (m_state == TAIL))});
    end
  end

  task automatic drive(input z80_bus_t b);
    @(posedge clk);
    bus <= b;
  endtask

  task automatic apply_reset(input logic [3:0] sw);
    @(posedge clk);
    reset_b <= 1'b0;
    dip     <= sw;
    bus     <= bus_idle;
    repeat (reset_cycles) @(posedge clk);
    reset_b <= 1'b1;
  endtask

  // Memory read, opcode fetch, write or refresh at a random address
  task automatic mem_cycle(input logic is_write, input logic is_fetch, input logic is_refresh);
    z80_bus_t b;
    b = bus_idle;
    b.adr15 = 1'($urandom_range(1));
    b.adr14 = 1'($urandom_range(1));
    b.adr8 = 1'($urandom_range(1));
    b.data = 8'($urandom);
    b.mreq_b = 1'b0;
    if (is_refresh) begin
      b.rfsh_b = 1'b0;
    end else if (!is_write) begin
      b.rd_b = 1'b0;
      b.m1_b = !is_fetch;
    end
    drive(b);
    // WR* falls one clock after MREQ*
    b.wr_b = !is_write;
    repeat ($urandom_range(3, 1)) drive(b);
    b.mreq_b = 1'b1;
    b.rd_b = 1'b1;
    b.wr_b = 1'b1;
    b.m1_b = 1'b1;
    b.rfsh_b = 1'b1;
    drive(b);
  endtask

  // I/O write to 7Fxx or 7Exx, mostly with the bank-select prefix
  task automatic io_write();
    z80_bus_t b;
    b = bus_idle;
    b.iorq_b = 1'b1;
    b.iorq_b = 1'b0;
    b.wr_b = 1'b0;
    b.adr15 = ($urandom_range(7) == 0);
    b.adr8 = 1'($urandom_range(1));
    b.data = 8'($urandom);
    if ($urandom_range(3) != 0) begin
      b.data[7:6] = bank_sel_prefix;
    end
    drive(b);
    // Later clocks of a long cycle carry new low data bits that must not reload the register
    repeat ($urandom_range(2)) begin
      b.data[5:0] = 6'($urandom);
      drive(b);
    end
    b.iorq_b = 1'b1;
    b.wr_b = 1'b1;
    drive(b);
  endtask

  task automatic random_cycle();
    int unsigned kind;
    kind = $urandom_range(9);
    if (kind < 3) begin
      mem_cycle(1'b1, 1'b0, 1'b0);
    end else if (kind < 5) begin
      mem_cycle(1'b0, 1'b0, 1'b0);
    end else if (kind == 5) begin
      mem_cycle(1'b0, 1'b1, 1'b0);
    end else if (kind == 6) begin
      mem_cycle(1'b0, 1'b0, 1'b1);
    end else begin
      io_write();
    end
    repeat ($urandom_range(2)) @(posedge clk);
  endtask

  initial begin
    void'($urandom(32'h6aa20b0a));
    clk = 1'b0;
    reset_b = 1'b0;
    dip = 4'h0;
    bus = bus_idle;
    model_valid = 1'b0;
    check_count = 0;
    for (int p = 0; p < num_phases; p++) begin
      apply_reset(phase_dips[p*4 +: 4]);
      repeat (num_txn) random_cycle();
    end
    // Ends on a rising edge so that the last falling-edge check is already counted
    repeat (4) @(posedge clk);
    $display("Errors: ram_cs_b=%0d ram_adr_hi=%0d ramdis=%0d a15_drive=%0d rd_drive=%0d in %0d checks",
             err_count[0], err_count[1], err_count[2], err_count[3], err_count[4], check_count);
    if (err_count.sum() == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog at twice the expected length of the run
  initial begin
    #(run_cycles * 8 * 2);
    $display("Timeout: the run did not complete within %0d clock periods", run_cycles * 2);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
rtl/cpc_bus_pkg.sv
rtl/ram_map_pkg.sv
rtl/bank_select_reg.sv
rtl/mem_cycle_fsm.sv
rtl/overdrive_timer.sv
rtl/block_mapper.sv
rtl/cpc_ram_expansion.sv
tests/tb_cpc_ram_expansion.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the result in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f vlog.f --top-module tb_cpc_ram_expansion -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
echo "Simulation did not pass"
exit 1
